/* common/isa_pkg.sv */
`include "mult_settings.svh"

package isa_pkg;

    // multiply flavours of the M extension
    // MUL keeps the low word, the other three keep the high word
    typedef enum logic [1:0] {
        MUL    = 2'd0,
        MULH   = 2'd1,
        MULHSU = 2'd2,
        MULHU  = 2'd3
    } mult_func_t;

    // one architectural data word
    typedef logic [`XLEN-1:0] data_t;

endpackage

/* common/mult_settings.svh */
`ifndef MULT_SETTINGS_SVH
`define MULT_SETTINGS_SVH

// multiplier pipeline depth, has to divide 64
`define MULT_STAGES 4

// operand and result width
`define XLEN 32

// physical register tag width
`define PHYS_TAG_WIDTH 5

// one bit per unresolved branch
`define BMASK_WIDTH 4

// depth of the multiply issue queue
`define ISSUE_SLOTS 4

`endif

/* common/ooo_pkg.sv */
`include "mult_settings.svh"

package ooo_pkg;
    import isa_pkg::*;

    // physical destination register
    typedef logic [`PHYS_TAG_WIDTH-1:0] phys_tag_t;
    // branches the op still depends on
    typedef logic [`BMASK_WIDTH-1:0] bmask_t;
    // ready table, one bit per physical register
    typedef logic [(1 << `PHYS_TAG_WIDTH)-1:0] ready_vec_t;
    // full double-width product
    typedef logic [2*`XLEN-1:0] product_t;

    // op as it leaves dispatch
    typedef struct packed {
        logic       valid;
        mult_func_t func;
        data_t      src1;
        data_t      src2;
        phys_tag_t  dest;
        bmask_t     mask;
    } mult_packet_t;

    // state handed from one multiplier stage to the next
    typedef struct packed {
        logic       valid;
        mult_func_t func;
        product_t   mcand;
        product_t   mplier;
        product_t   sum;
        phys_tag_t  dest;
        bmask_t     mask;
    } internal_mult_packet_t;

    localparam internal_mult_packet_t nop_mult_packet = '{
        valid:  1'b0,
        func:   MUL,
        mcand:  '0,
        mplier: '0,
        sum:    '0,
        dest:   '0,
        mask:   '0
    };

    // common data bus broadcast
    typedef struct packed {
        logic      valid;
        phys_tag_t dest;
        data_t     result;
    } cdb_packet_t;

endpackage

/* hw/cdb_writeback.sv */
module cdb_writeback (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  cdb_busy,
    input  ooo_pkg::cdb_packet_t  mult_result,
    input  ooo_pkg::mult_packet_t dispatch,
    output logic                  cdb_en,
    output ooo_pkg::cdb_packet_t  cdb_out,
    output ooo_pkg::ready_vec_t   phys_ready
);

    // the multiplier owns the bus whenever nobody else does
    assign cdb_en = !cdb_busy;

    // broadcast register
    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_out.valid <= 1'b0;
        end else if (cdb_en) begin
            cdb_out <= mult_result;
        end else begin
            // lost the bus, last stage keeps the op for a later cycle
            cdb_out.valid <= 1'b0;
        end
    end

    // ready table
    // bit rises on the same edge that puts the result on the bus
    always_ff @(posedge clock) begin
        if (reset) begin
            phys_ready <= '1;
        end else begin
            if (cdb_en && mult_result.valid) begin
                phys_ready[mult_result.dest] <= 1'b1;
            end
            // new producer for the tag, this clear takes priority
            if (dispatch.valid) begin
                phys_ready[dispatch.dest] <= 1'b0;
            end
        end
    end

endmodule

/* hw/mult/mult_stage.sv */
`include "mult_settings.svh"

module mult_stage (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           is_last_stage,
    input  logic                           next_stage_free,
    input  ooo_pkg::internal_mult_packet_t packet_in,
    input  ooo_pkg::bmask_t                b_resolve,
    input  logic                           b_mispred,
    output logic                           stage_free,
    output ooo_pkg::internal_mult_packet_t packet_out
);
    import ooo_pkg::*;

    // multiplier bits consumed per stage
    localparam int SHIFT = $bits(product_t) / `MULT_STAGES;

    internal_mult_packet_t held;
    internal_mult_packet_t held_br;

    // branch update on the held op
    always_comb begin
        held_br = held;
        if (|(held.mask & b_resolve)) begin
            held_br.mask = held.mask & ~b_resolve;
            if (b_mispred) begin
                held_br.valid = 1'b0;
            end
        end
    end

    // add one partial product, then line up the next chunk
    always_comb begin
        packet_out        = held_br;
        packet_out.sum    = held.sum + held.mplier[SHIFT-1:0] * held.mcand;
        packet_out.mplier = held.mplier >> SHIFT;
        packet_out.mcand  = held.mcand << SHIFT;
    end

    // an empty stage can always take a packet, except the last one,
    // which only moves when it owns the bus
    assign stage_free = next_stage_free || (!held_br.valid && !is_last_stage);

    always_ff @(posedge clock) begin
        if (reset) begin
            held <= nop_mult_packet;
        end else if (stage_free) begin
            held <= packet_in;
        end else begin
            // stalled, keep the op but remember any squash or cleared bit
            held <= held_br;
        end
    end

endmodule

/* hw/mult/mult_unit.sv */
`include "mult_settings.svh"

module mult_unit (
    input  logic                  clock,
    input  logic                  reset,
    input  ooo_pkg::mult_packet_t issue,
    input  ooo_pkg::bmask_t       b_resolve,
    input  logic                  b_mispred,
    input  logic                  cdb_en,
    output logic                  fu_free,
    output ooo_pkg::cdb_packet_t  mult_result
);
    import isa_pkg::*;
    import ooo_pkg::*;

    internal_mult_packet_t prepared;
    internal_mult_packet_t final_pkt;
    internal_mult_packet_t stage_out [`MULT_STAGES];
    // stage_free[k] is the free level of stage k, the top bit is the bus
    logic [`MULT_STAGES:0] stage_free;
    logic                  mcand_signed;
    logic                  mplier_signed;

    // rs1 is signed unless MULHU, rs2 only for MUL and MULH
    assign mcand_signed  = (issue.func != MULHU);
    assign mplier_signed = (issue.func == MUL) || (issue.func == MULH);

    always_comb begin
        prepared.valid  = issue.valid;
        prepared.func   = issue.func;
        prepared.mcand  = {{`XLEN{mcand_signed && issue.src1[`XLEN-1]}}, issue.src1};
        prepared.mplier = {{`XLEN{mplier_signed && issue.src2[`XLEN-1]}}, issue.src2};
        prepared.sum    = '0;
        prepared.dest   = issue.dest;
        prepared.mask   = issue.mask;
    end

    assign stage_free[`MULT_STAGES] = cdb_en;
    assign fu_free                  = stage_free[0];

    for (genvar k = 0; k < `MULT_STAGES; k++) begin : g_stage
        internal_mult_packet_t packet_in;

        if (k == 0) begin : g_first
            assign packet_in = prepared;
        end else begin : g_rest
            assign packet_in = stage_out[k-1];
        end

        mult_stage mult_stage_i (
            .clock           (clock),
            .reset           (reset),
            .is_last_stage   (k == `MULT_STAGES - 1),
            .next_stage_free (stage_free[k+1]),
            .packet_in       (packet_in),
            .b_resolve       (b_resolve),
            .b_mispred       (b_mispred),
            .stage_free      (stage_free[k]),
            .packet_out      (stage_out[k])
        );
    end

    assign final_pkt = stage_out[`MULT_STAGES-1];

    // low word for MUL, high word for the MULH forms
    always_comb begin
        mult_result.valid = final_pkt.valid;
        mult_result.dest  = final_pkt.dest;
        if (final_pkt.func == MUL) begin
            mult_result.result = final_pkt.sum[`XLEN-1:0];
        end else begin
            mult_result.result = final_pkt.sum[2*`XLEN-1:`XLEN];
        end
    end

endmodule

/* hw/mult_issue_slots.sv */
`include "mult_settings.svh"

module mult_issue_slots (
    input  logic                  clock,
    input  logic                  reset,
    input  ooo_pkg::mult_packet_t dispatch,
    input  ooo_pkg::bmask_t       b_resolve,
    input  logic                  b_mispred,
    input  logic                  fu_free,
    output ooo_pkg::mult_packet_t issue,
    output logic                  slots_full
);
    import ooo_pkg::*;

    localparam int PTR_WIDTH = (`ISSUE_SLOTS > 1) ? $clog2(`ISSUE_SLOTS) : 1;

    typedef logic [PTR_WIDTH-1:0] slot_ptr_t;
    typedef logic [$clog2(`ISSUE_SLOTS+1)-1:0] slot_count_t;

    // queue storage, and its contents after this cycle's branch update
    mult_packet_t slots    [`ISSUE_SLOTS];
    mult_packet_t slots_br [`ISSUE_SLOTS];
    mult_packet_t dispatch_br;
    slot_ptr_t    head;
    slot_ptr_t    tail;
    slot_count_t  count;
    logic         push;
    logic         pop;

    // mispredict kills the op, a correct resolve only drops the mask bit
    function automatic mult_packet_t apply_branch(mult_packet_t pkt, bmask_t resolve,
                                                  logic mispred);
        mult_packet_t res;
        res = pkt;
        if (|(pkt.mask & resolve)) begin
            res.mask = pkt.mask & ~resolve;
            if (mispred) begin
                res.valid = 1'b0;
            end
        end
        return res;
    endfunction

    // wrap at the queue depth, which need not be a power of two
    function automatic slot_ptr_t next_ptr(slot_ptr_t ptr);
        if (ptr == slot_ptr_t'(`ISSUE_SLOTS-1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_comb begin
        for (int i = 0; i < `ISSUE_SLOTS; i++) begin
            slots_br[i] = apply_branch(slots[i], b_resolve, b_mispred);
        end
    end

    // an op may meet its own branch on the dispatch cycle
    assign dispatch_br = apply_branch(dispatch, b_resolve, b_mispred);

    assign slots_full = (count == slot_count_t'(`ISSUE_SLOTS));
    assign push       = dispatch_br.valid && !slots_full;
    // squashed head entries still pop, they go down as bubbles
    assign pop        = fu_free && (count != '0);

    always_comb begin
        issue = slots_br[head];
        if (count == '0) begin
            issue.valid = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        slots <= slots_br;
        if (push) begin
            slots[tail] <= dispatch_br;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= next_ptr(tail);
            end
            if (pop) begin
                head <= next_ptr(head);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hw/mult_subsystem_top.sv */
module mult_subsystem_top (
    input  logic                  clock,
    input  logic                  reset,
    input  ooo_pkg::mult_packet_t dispatch,
    input  ooo_pkg::bmask_t       b_resolve,
    input  logic                  b_mispred,
    input  logic                  cdb_busy,
    output logic                  slots_full,
    output ooo_pkg::cdb_packet_t  cdb_out,
    output ooo_pkg::ready_vec_t   phys_ready
);
    import ooo_pkg::*;

    // head of the issue queue into the multiplier
    mult_packet_t issue;
    // last stage output toward the bus
    cdb_packet_t  mult_result;
    logic         fu_free;
    logic         cdb_en;

    mult_issue_slots mult_issue_slots_i (
        .clock      (clock),
        .reset      (reset),
        .dispatch   (dispatch),
        .b_resolve  (b_resolve),
        .b_mispred  (b_mispred),
        .fu_free    (fu_free),
        .issue      (issue),
        .slots_full (slots_full)
    );

    mult_unit mult_unit_i (
        .clock       (clock),
        .reset       (reset),
        .issue       (issue),
        .b_resolve   (b_resolve),
        .b_mispred   (b_mispred),
        .cdb_en      (cdb_en),
        .fu_free     (fu_free),
        .mult_result (mult_result)
    );

    // also sees dispatch to clear ready bits of new destinations
    cdb_writeback cdb_writeback_i (
        .clock       (clock),
        .reset       (reset),
        .cdb_busy    (cdb_busy),
        .mult_result (mult_result),
        .dispatch    (dispatch),
        .cdb_en      (cdb_en),
        .cdb_out     (cdb_out),
        .phys_ready  (phys_ready)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the multiply subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f src.f \
    --top-module mult_subsystem_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/Vmult_subsystem_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
    exit 0
fi
exit 1

/* src.f */
+incdir+common
common/isa_pkg.sv
common/ooo_pkg.sv
hw/mult_issue_slots.sv
hw/mult/mult_stage.sv
hw/mult/mult_unit.sv
hw/cdb_writeback.sv
hw/mult_subsystem_top.sv
verification/mult_subsystem_tb.sv

/* verification/mult_subsystem_tb.sv */
`include "mult_settings.svh"

module mult_subsystem_tb;
    import isa_pkg::*;
    import ooo_pkg::*;

    localparam int NUM_TAGS     = 1 << `PHYS_TAG_WIDTH;
    localparam int PLAIN_OPS    = 60;
    localparam int PRESSURE_OPS = 60;
    localparam int BRANCH_OPS   = 80;
    localparam int TOTAL_OPS    = PLAIN_OPS + PRESSURE_OPS + BRANCH_OPS;

    logic         clock;
    logic         reset;
    mult_packet_t dispatch;
    bmask_t       b_resolve;
    logic         b_mispred;
    logic         cdb_busy;
    logic         slots_full;
    cdb_packet_t  cdb_out;
    ready_vec_t   phys_ready;

    // model state indexed by tag
    logic        live [NUM_TAGS];
    bmask_t      model_mask [NUM_TAGS];
    data_t       expected [NUM_TAGS];
    ready_vec_t  model_ready;
    phys_tag_t   free_tags [$];
    int          outstanding;
    int          errors;
    int          n_dispatched;
    int          n_broadcast;
    int          n_squashed;
    bmask_t      open_br;
    logic [31:0] lfsr_state;

    mult_subsystem_top mult_subsystem_top_i (
        .clock      (clock),
        .reset      (reset),
        .dispatch   (dispatch),
        .b_resolve  (b_resolve),
        .b_mispred  (b_mispred),
        .cdb_busy   (cdb_busy),
        .slots_full (slots_full),
        .cdb_out    (cdb_out),
        .phys_ready (phys_ready)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // galois lfsr stepped once per bit handed out
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'ha300_0000 : 32'h0);
        end
        return val;
    endfunction

    // product word straight from the M extension definitions
    function automatic data_t product_word(mult_func_t f, data_t a, data_t b);
        longint      sp;
        logic [63:0] up;
        case (f)
            MUL: begin
                up = 64'(a) * 64'(b);
                return up[31:0];
            end
            MULH: begin
                sp = longint'($signed(a)) * longint'($signed(b));
                return sp[63:32];
            end
            MULHSU: begin
                sp = longint'($signed(a)) * longint'({32'b0, b});
                return sp[63:32];
            end
            default: begin
                up = 64'(a) * 64'(b);
                return up[63:32];
            end
        endcase
    endfunction

    // table as the DUT shows it with the broadcast on the bus already counted
    function automatic ready_vec_t ready_expected(ready_vec_t r, cdb_packet_t c);
        ready_vec_t res;
        res = r;
        if (c.valid) begin
            res[c.dest] = 1'b1;
        end
        return res;
    endfunction

    // model update on each edge from the values of the cycle before it
    always @(posedge clock) begin
        logic   hit;
        bmask_t m;
        if (reset) begin
            model_ready <= '1;
            for (int t = 0; t < NUM_TAGS; t++) begin
                live[t] <= 1'b0;
            end
        end else begin
            hit = cdb_out.valid && live[cdb_out.dest];
            if (hit) begin
                live[cdb_out.dest]        <= 1'b0;
                model_ready[cdb_out.dest] <= 1'b1;
                free_tags.push_back(cdb_out.dest);
                outstanding--;
                n_broadcast++;
            end
            // branch rule on ops still held somewhere in the DUT
            for (int t = 0; t < NUM_TAGS; t++) begin
                if (live[t] && !(hit && cdb_out.dest == phys_tag_t'(t)) &&
                    |(model_mask[t] & b_resolve)) begin
                    if (b_mispred) begin
                        live[t] <= 1'b0;
                        free_tags.push_back(phys_tag_t'(t));
                        outstanding--;
                        n_squashed++;
                    end else begin
                        model_mask[t] <= model_mask[t] & ~b_resolve;
                    end
                end
            end
            if (dispatch.valid && !slots_full) begin
                model_ready[dispatch.dest] <= 1'b0;
                n_dispatched++;
                m = dispatch.mask;
                if (|(m & b_resolve) && b_mispred) begin
                    // killed on its own dispatch cycle
                    free_tags.push_back(dispatch.dest);
                    n_squashed++;
                end else begin
                    live[dispatch.dest]       <= 1'b1;
                    model_mask[dispatch.dest] <= m & ~b_resolve;
                    expected[dispatch.dest]   <=
                        product_word(dispatch.func, dispatch.src1, dispatch.src2);
                    outstanding++;
                end
            end
        end
    end

    // quiet outputs in reset and in the cycle after it
    assert property (@(posedge clock) $past(reset) |->
                     !cdb_out.valid && !slots_full && &phys_ready)
    else begin
        errors++;
        $display({"CHECK FAILED at %0t: cdb_out.valid/slots_full/phys_ready ",
                  "expected 0/0/%h got %b/%b/%h"},
                 $time, {NUM_TAGS{1'b1}}, $sampled(cdb_out.valid), $sampled(slots_full),
                 $sampled(phys_ready));
    end

    // broadcast must belong to a live, unsquashed op
    assert property (@(posedge clock) disable iff (reset)
                     cdb_out.valid |-> live[cdb_out.dest])
    else begin
        errors++;
        $display("broadcast of tag %0d at %0t, which is not in flight or was squashed",
                 $sampled(cdb_out.dest), $time);
    end

    assert property (@(posedge clock) disable iff (reset)
                     cdb_out.valid && live[cdb_out.dest] |->
                     cdb_out.result == expected[cdb_out.dest])
    else begin
        errors++;
        $display("CHECK FAILED at %0t: cdb_out.result expected %h got %h", $time,
                 $sampled(expected[cdb_out.dest]), $sampled(cdb_out.result));
    end

    // no broadcast right after the bus was taken by someone else
    assert property (@(posedge clock) disable iff (reset)
                     $past(cdb_busy) |-> !cdb_out.valid)
    else begin
        errors++;
        $display("CHECK FAILED at %0t: cdb_out.valid expected 0 got 1", $time);
    end

    assert property (@(posedge clock) disable iff (reset)
                     phys_ready == ready_expected(model_ready, cdb_out))
    else begin
        errors++;
        $display("CHECK FAILED at %0t: phys_ready expected %h got %h", $time,
                 $sampled(ready_expected(model_ready, cdb_out)), $sampled(phys_ready));
    end

    task automatic drive_idle();
        dispatch  = '0;
        b_resolve = '0;
        b_mispred = 1'b0;
        cdb_busy  = 1'b0;
    endtask

    task automatic report_phase(string name, int errors_before);
        if (errors == errors_before) begin
            $display("phase %s: pass", name);
        end else begin
            $display("phase %s: FAIL with %0d errors", name, errors - errors_before);
        end
    endtask

    // n ops with optional bus pressure and branch traffic and then a drain
    task automatic run_phase(string name, int n, bit busy_mode, bit branch_mode);
        int sent;
        int errors_before;
        int idx;
        errors_before = errors;
        sent = 0;
        while (sent < n) begin
            @(negedge clock);
            drive_idle();
            if (busy_mode) begin
                cdb_busy = 1'(rand_bits(1));
            end
            if (branch_mode && open_br != '0 && rand_bits(3) == 0) begin
                idx = rand_bits(2);
                while (!open_br[idx]) begin
                    idx = (idx + 1) % `BMASK_WIDTH;
                end
                b_resolve = bmask_t'(1) << idx;
                b_mispred = 1'(rand_bits(1));
                open_br   = open_br & ~b_resolve;
            end else if (branch_mode && open_br != '1 && rand_bits(2) == 0) begin
                idx = rand_bits(2);
                while (open_br[idx]) begin
                    idx = (idx + 1) % `BMASK_WIDTH;
                end
                open_br[idx] = 1'b1;
            end
            if (!slots_full && free_tags.size() > 0 && rand_bits(2) != 0) begin
                dispatch.valid = 1'b1;
                dispatch.dest  = free_tags.pop_front();
                dispatch.func  = mult_func_t'(rand_bits(2));
                dispatch.src1  = rand_bits(32);
                dispatch.src2  = rand_bits(32);
                dispatch.mask  = open_br;
                sent++;
            end
        end
        @(negedge clock);
        drive_idle();
        while (outstanding != 0) begin
            @(negedge clock);
        end
        open_br = '0;
        report_phase(name, errors_before);
    endtask

    // watchdog sized from the op count
    initial begin
        #((40 * TOTAL_OPS + 200) * 8);
        $display("watchdog: run did not finish within %0d cycles", 40 * TOTAL_OPS + 200);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int errors_before;
        lfsr_state   = 32'h39f5_1d1d;
        errors       = 0;
        outstanding  = 0;
        n_dispatched = 0;
        n_broadcast  = 0;
        n_squashed   = 0;
        open_br      = '0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            free_tags.push_back(phys_tag_t'(t));
        end
        drive_idle();
        reset = 1'b1;
        errors_before = errors;
        repeat (8) @(negedge clock);
        reset = 1'b0;
        repeat (2) @(negedge clock);
        report_phase("reset", errors_before);

        run_phase("plain stream", PLAIN_OPS, 1'b0, 1'b0);
        run_phase("bus pressure", PRESSURE_OPS, 1'b1, 1'b0);
        run_phase("branch squash/resolve", BRANCH_OPS, 1'b1, 1'b1);
        repeat (2) @(negedge clock);

        $display("dispatched %0d, broadcast %0d, squashed %0d, errors %0d",
                 n_dispatched, n_broadcast, n_squashed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
